// File: pipeline_cpu.f
cpu_pkg.sv
reg_file.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
pipeline_cpu.sv
pipeline_cpu_tb.sv

// File: pipeline_cpu_tb.sv
module pipeline_cpu_tb;

  localparam logic [31:0] start_pc = 32'h100;
  localparam int imem_addr_bits  = 16;
  localparam int dmem_addr_bits  = 16;
  localparam int clk_period      = 20;
  localparam int wait_bound      = 200; // Cycles allowed for a program to store
  localparam int num_tests       = 6;
  localparam int cycles_per_test = 230;

  logic                      clk;
  logic                      reset;
  logic [3:0]                key;
  logic                      imem_we;
  logic [imem_addr_bits-1:0] imem_addr;
  logic [31:0]               imem_data;
  logic [23:0]               hex;
  logic [9:0]                ledr;

  logic [31:0] prog [$]; // Program words, first one goes to start_pc

  pipeline_cpu #(
    .start_pc       (start_pc),
    .imem_addr_bits (imem_addr_bits),
    .dmem_addr_bits (dmem_addr_bits)
  ) dut0 (
    .clk       (clk),
    .reset     (reset),
    .key       (key),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .hex       (hex),
    .ledr      (ledr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(num_tests * cycles_per_test * clk_period);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  // Encoding --------------------
  function automatic logic [31:0] r_word(input cpu_pkg::op2_t op2, input logic [3:0] rd,
                                         input logic [3:0] rs, input logic [3:0] rt);
    return {cpu_pkg::op1_alur, op2, 6'b000000, rd, rs, rt};
  endfunction

  function automatic logic [31:0] i_word(input cpu_pkg::op1_t op1, input logic [3:0] rs,
                                         input logic [3:0] rt, input logic [15:0] imm);
    return {op1, 2'b00, imm, rs, rt};
  endfunction

  function automatic logic [31:0] sext(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // Helpers --------------------
  task automatic step();
    @(posedge clk);
    #2; // Drive and sample away from the edge
  endtask

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  // Holds reset, writes prog plus a self loop, then releases the core
  task automatic load_and_start();
    int n;
    prog.push_back(i_word(cpu_pkg::op1_beq, 4'd0, 4'd0, 16'hFFFF)); // Branch to itself
    repeat (3) prog.push_back(32'h0); // Words fetched in the loop's shadow
    reset = 1'b1;
    repeat (3) step();
    for (n = 0; n < prog.size(); n++) begin
      imem_we   = 1'b1;
      imem_addr = imem_addr_bits'((start_pc >> 2) + 32'(n));
      imem_data = prog[n];
      step();
    end
    imem_we = 1'b0;
    step();
    reset = 1'b0;
    prog.delete();
  endtask

  task automatic wait_for_output();
    int cycles;
    cycles = 0;
    while (hex == 24'hFEDEAD && ledr == 10'd0) begin
      if (cycles == wait_bound)
        fail_now("No store reached hex or ledr within the cycle bound");
      step();
      cycles++;
    end
  endtask

  task automatic check_hex(input logic [23:0] expected);
    assert (hex == expected) else
      fail_now($sformatf("FAILED hex: got %h, expected %h", hex, expected));
  endtask

  task automatic check_ledr(input logic [9:0] expected);
    assert (ledr == expected) else
      fail_now($sformatf("FAILED ledr: got %h, expected %h", ledr, expected));
  endtask

  // Tests --------------------
  task automatic test_reset_values();
    reset = 1'b1;
    step();
    check_hex(24'hFEDEAD);
    check_ledr(10'd0);
    load_and_start(); // Only the self loop, no stores
    repeat (20) step();
    check_hex(24'hFEDEAD);
    check_ledr(10'd0);
  endtask

  task automatic test_alu_chain();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] c;
    logic [31:0] sh;
    logic [31:0] res;
    a  = 16'($urandom);
    b  = 16'($urandom);
    c  = 16'($urandom);
    sh = $urandom % 8;
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd1, a));
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd2, b));
    prog.push_back(r_word(cpu_pkg::op2_add, 4'd3, 4'd1, 4'd2));  // r3 = r1 + r2
    prog.push_back(r_word(cpu_pkg::op2_sub, 4'd4, 4'd1, 4'd3));  // r4 = r1 - r3
    prog.push_back(r_word(cpu_pkg::op2_nor, 4'd5, 4'd4, 4'd1));
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd6, sh[15:0]));
    prog.push_back(r_word(cpu_pkg::op2_lshf, 4'd7, 4'd5, 4'd6));
    prog.push_back(i_word(cpu_pkg::op1_ori, 4'd7, 4'd8, c));
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd8, 16'hF000)); // To hex
    res = sext(a) - (sext(a) + sext(b));
    res = ~(res | sext(a));
    res = res << sh;
    res = res | sext(c);
    load_and_start();
    wait_for_output();
    check_hex(res[23:0]);
  endtask

  task automatic test_memory();
    logic [15:0] x;
    logic [15:0] y;
    logic [15:0] daddr;
    logic [31:0] sum;
    x     = 16'($urandom);
    y     = 16'($urandom);
    daddr = 16'(32'h200 + 4 * ($urandom % 64));
    sum   = sext(x) + sext(y);
    if (sum[9:0] == 10'd0) begin
      y   = y + 16'd1; // Keep ledr off its reset value
      sum = sext(x) + sext(y);
    end
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd1, x));
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd2, y));
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd1, daddr));
    prog.push_back(i_word(cpu_pkg::op1_lw, 4'd0, 4'd3, daddr));
    prog.push_back(r_word(cpu_pkg::op2_add, 4'd4, 4'd3, 4'd2));
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd4, 16'hF020)); // To ledr
    load_and_start();
    wait_for_output();
    check_ledr(sum[9:0]);
  endtask

  // Branch to word i + 1 + imm
  task automatic test_branches();
    logic [15:0] v;
    logic [15:0] marker;
    logic [31:0] expected;
    v        = 16'($urandom);
    marker   = 16'($urandom);
    expected = sext(marker);
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd1, v));       // 0
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd2, v));       // 1
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd3, ~marker)); // 2, wrong value
    prog.push_back(i_word(cpu_pkg::op1_beq, 4'd1, 4'd2, 16'd3));    // 3, taken to 7
    repeat (3) prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd3, 16'hF000));
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd4, 16'd1));   // 7
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd5, 16'hFFFF));
    prog.push_back(i_word(cpu_pkg::op1_blt, 4'd4, 4'd5, 16'd3));    // 9, 1 < -1 is false
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd6, marker));
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd6, 16'hF000));
    prog.push_back(i_word(cpu_pkg::op1_beq, 4'd0, 4'd0, 16'hFFFF)); // 12
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd3, 16'hF000));  // 13, BLT target
    load_and_start();
    wait_for_output();
    check_hex(expected[23:0]);
  endtask

  task automatic test_jal();
    logic [15:0] bad;
    logic [31:0] link;
    bad  = {4'hA, 12'($urandom)};
    link = start_pc + 32'd4 * 2 + 32'd4; // JAL sits at word 2
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd1, start_pc[15:0]));
    prog.push_back(i_word(cpu_pkg::op1_addi, 4'd0, 4'd3, bad));
    prog.push_back(i_word(cpu_pkg::op1_jal, 4'd1, 4'd2, 16'd8)); // r1 + 32 is word 8
    repeat (5) prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd3, 16'hF000));
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd2, 16'hF000)); // Link to hex
    load_and_start();
    wait_for_output();
    check_hex(link[23:0]);
  endtask

  task automatic test_key_read();
    logic [3:0] kv;
    kv  = 4'($urandom % 15); // All released would leave ledr at 0
    key = kv;
    prog.push_back(i_word(cpu_pkg::op1_lw, 4'd0, 4'd1, 16'hF080));
    prog.push_back(i_word(cpu_pkg::op1_sw, 4'd0, 4'd1, 16'hF020));
    load_and_start();
    wait_for_output();
    check_ledr({6'b000000, ~kv});
    key = 4'hF;
  endtask

  initial begin
    int unsigned seed;
    seed = 32'h2f9;
    void'($urandom(seed));
    reset     = 1'b1;
    key       = 4'hF; // Active low, nothing pressed
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    test_reset_values();
    test_alu_chain();
    test_memory();
    test_branches();
    test_jal();
    test_key_read();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: pipeline_cpu.sv
module pipeline_cpu #(
  parameter logic [cpu_pkg::dbits-1:0] start_pc = 32'h100,
  parameter int imem_addr_bits = 16,
  parameter int dmem_addr_bits = 16
) (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cpu_pkg::key_bits-1:0]    key,
  input  logic                            imem_we,
  input  logic [imem_addr_bits-1:0]       imem_addr,
  input  logic [cpu_pkg::dbits-1:0]       imem_data,
  output logic [cpu_pkg::hex_bits-1:0]    hex,
  output logic [cpu_pkg::ledr_bits-1:0]   ledr
);

  cpu_pkg::fe_id_t    fe_id;
  cpu_pkg::id_ex_t    id_ex;
  cpu_pkg::ex_mem_t   ex_mem;
  cpu_pkg::mem_wb_t   wb;
  cpu_pkg::redirect_t redirect;
  logic               stall;

  fetch_stage #(
    .start_pc       (start_pc),
    .imem_addr_bits (imem_addr_bits)
  ) u_fetch (
    .clk       (clk),
    .reset     (reset),
    .stall     (stall),
    .redirect  (redirect),
    .imem_we   (imem_we),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .fe_id     (fe_id)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .fe_id      (fe_id),
    .redirect   (redirect),
    .ex_wregno  (ex_mem.wregno),
    .mem_wregno (wb.wregno),
    .wb         (wb),
    .stall      (stall),
    .id_ex      (id_ex)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .id_ex    (id_ex),
    .redirect (redirect),
    .ex_mem   (ex_mem)
  );

  mem_stage #(
    .dmem_addr_bits (dmem_addr_bits)
  ) u_mem (
    .clk    (clk),
    .reset  (reset),
    .ex_mem (ex_mem),
    .key    (key),
    .wb     (wb),
    .hex    (hex),
    .ledr   (ledr)
  );

endmodule

// File: mem_stage.sv
module mem_stage #(
  parameter int dmem_addr_bits = 16
) (
  input  logic                               clk,
  input  logic                               reset,
  input  cpu_pkg::ex_mem_t                   ex_mem,
  input  logic [cpu_pkg::key_bits-1:0]       key,  // Active low
  output cpu_pkg::mem_wb_t                   wb,
  output logic [cpu_pkg::hex_bits-1:0]       hex,
  output logic [cpu_pkg::ledr_bits-1:0]      ledr
);

  localparam int dmem_words = 1 << (dmem_addr_bits - 2);

  logic [cpu_pkg::dbits-1:0] dmem [dmem_words];
  logic [cpu_pkg::dbits-1:0] addr;
  logic [cpu_pkg::dbits-1:0] rd_val;
  logic                      is_hex;
  logic                      is_ledr;
  logic                      is_key;

  assign addr    = ex_mem.aluout;
  assign is_hex  = (addr == cpu_pkg::addr_hex);
  assign is_ledr = (addr == cpu_pkg::addr_ledr);
  assign is_key  = (addr == cpu_pkg::addr_key);

  // Data memory --------------------
  always_ff @(posedge clk) begin
    if (ex_mem.wr_mem && !is_hex && !is_ledr)
      dmem[addr[dmem_addr_bits-1:2]] <= ex_mem.sdata;
  end

  assign rd_val = is_key ? {{(cpu_pkg::dbits - cpu_pkg::key_bits){1'b0}}, ~key}
                         : dmem[addr[dmem_addr_bits-1:2]];

  // I/O registers --------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex  <= 24'hFEDEAD;
      ledr <= '0;
    end else if (ex_mem.wr_mem) begin
      if (is_hex)
        hex <= ex_mem.sdata[cpu_pkg::hex_bits-1:0];
      if (is_ledr)
        ledr <= ex_mem.sdata[cpu_pkg::ledr_bits-1:0];
    end
  end

  // Write-back latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb.wval   <= ex_mem.rd_mem ? rd_val : ex_mem.aluout;
      wb.wregno <= ex_mem.wregno;
      wb.wr_reg <= ex_mem.wr_reg;
    end
  end

  a_mem_excl: assert property (@(posedge clk) disable iff (reset)
    !(ex_mem.rd_mem && ex_mem.wr_mem));

endmodule

// File: execute_stage.sv
module execute_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  cpu_pkg::id_ex_t      id_ex,
  output cpu_pkg::redirect_t   redirect,
  output cpu_pkg::ex_mem_t     ex_mem
);

  logic [cpu_pkg::dbits-1:0] a;
  logic [cpu_pkg::dbits-1:0] b;
  logic [cpu_pkg::dbits-1:0] imm4;
  logic [cpu_pkg::dbits-1:0] aluout;
  logic [cpu_pkg::dbits-1:0] target;
  logic                      br_cond;
  logic                      taken;

  assign a    = id_ex.regval1;
  assign b    = id_ex.regval2;
  assign imm4 = {id_ex.imm[cpu_pkg::dbits-3:0], 2'b00};

  // ALU --------------------
  always_comb begin
    aluout = '0;
    case (id_ex.op1)
      cpu_pkg::op1_alur: begin
        case (id_ex.op2)
          cpu_pkg::op2_eq:   aluout = {31'd0, a == b};
          cpu_pkg::op2_lt:   aluout = {31'd0, $signed(a) < $signed(b)};
          cpu_pkg::op2_le:   aluout = {31'd0, $signed(a) <= $signed(b)};
          cpu_pkg::op2_ne:   aluout = {31'd0, a != b};
          cpu_pkg::op2_add:  aluout = a + b;
          cpu_pkg::op2_and:  aluout = a & b;
          cpu_pkg::op2_or:   aluout = a | b;
          cpu_pkg::op2_xor:  aluout = a ^ b;
          cpu_pkg::op2_sub:  aluout = a - b;
          cpu_pkg::op2_nand: aluout = ~(a & b);
          cpu_pkg::op2_nor:  aluout = ~(a | b);
          cpu_pkg::op2_nxor: aluout = ~(a ^ b);
          cpu_pkg::op2_rshf: aluout = $signed(a) >>> b; // Arithmetic
          cpu_pkg::op2_lshf: aluout = a << b;
          default:           aluout = '0;
        endcase
      end
      cpu_pkg::op1_lw,
      cpu_pkg::op1_sw,
      cpu_pkg::op1_addi: aluout = a + id_ex.imm; // Also the memory address
      cpu_pkg::op1_andi: aluout = a & id_ex.imm;
      cpu_pkg::op1_ori:  aluout = a | id_ex.imm;
      cpu_pkg::op1_xori: aluout = a ^ id_ex.imm;
      cpu_pkg::op1_jal:  aluout = id_ex.pc_plus;  // Link value
      default:           aluout = '0;
    endcase
  end

  // Branch resolution --------------------
  always_comb begin
    case (id_ex.op1)
      cpu_pkg::op1_beq: br_cond = (a == b);
      cpu_pkg::op1_blt: br_cond = ($signed(a) < $signed(b));
      cpu_pkg::op1_ble: br_cond = ($signed(a) <= $signed(b));
      cpu_pkg::op1_bne: br_cond = (a != b);
      default:          br_cond = 1'b0;
    endcase
  end

  assign taken  = id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond);
  assign target = id_ex.ctrl.is_jmp ? (a + imm4) : (id_ex.pc_plus + imm4);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      redirect <= '0;
      ex_mem   <= '0;
    end else if (redirect.valid) begin
      // Instruction here came down the wrong path
      redirect <= '0;
      ex_mem   <= '0;
    end else begin
      redirect.valid  <= taken;
      redirect.target <= target;
      ex_mem.aluout   <= aluout;
      ex_mem.sdata    <= b;
      ex_mem.wregno   <= id_ex.wregno;
      ex_mem.rd_mem   <= id_ex.ctrl.rd_mem;
      ex_mem.wr_mem   <= id_ex.ctrl.wr_mem;
      ex_mem.wr_reg   <= id_ex.ctrl.wr_reg;
    end
  end

  // Decode latch is flushed on the redirect edge
  a_redirect_flush: assert property (@(posedge clk) disable iff (reset)
    redirect.valid |=> (id_ex == '0));

endmodule

// File: decode_stage.sv
module decode_stage (
  input  logic                             clk,
  input  logic                             reset,
  input  cpu_pkg::fe_id_t                  fe_id,
  input  cpu_pkg::redirect_t               redirect,
  input  logic [cpu_pkg::regno_bits-1:0]   ex_wregno,  // Destination in ex_mem
  input  logic [cpu_pkg::regno_bits-1:0]   mem_wregno, // Destination in mem_wb
  input  cpu_pkg::mem_wb_t                 wb,
  output logic                             stall,
  output cpu_pkg::id_ex_t                  id_ex
);

  cpu_pkg::inst_u               inst;
  cpu_pkg::op1_t                op1;
  cpu_pkg::ctrl_t               ctrl;
  logic                         is_alur;
  logic                         writes_class;
  logic                         uses_rt;
  logic [cpu_pkg::regno_bits-1:0] dest;
  logic [cpu_pkg::regno_bits-1:0] wregno;
  logic [cpu_pkg::dbits-1:0]    regval1;
  logic [cpu_pkg::dbits-1:0]    regval2;
  logic [cpu_pkg::dbits-1:0]    sxt_imm;

  // True when regno is waiting to be written by an older instruction
  function automatic logic pending(input logic [cpu_pkg::regno_bits-1:0] regno,
                                   input logic [cpu_pkg::regno_bits-1:0] w_ex,
                                   input logic [cpu_pkg::regno_bits-1:0] w_mem,
                                   input logic [cpu_pkg::regno_bits-1:0] w_wb);
    return (regno != '0) && (regno == w_ex || regno == w_mem || regno == w_wb);
  endfunction

  assign inst = fe_id.inst;
  assign op1  = inst.r.op1;

  reg_file u_regs (
    .clk   (clk),
    .reset (reset),
    .rs    (inst.r.rs),
    .rt    (inst.r.rt),
    .wb    (wb),
    .rval1 (regval1),
    .rval2 (regval2)
  );

  // Control decode --------------------
  assign is_alur      = (op1 == cpu_pkg::op1_alur);
  assign writes_class = is_alur || (op1 == cpu_pkg::op1_jal) ||
                        (op1 == cpu_pkg::op1_lw) || (op1[5:3] == 3'b100);
  assign dest         = is_alur ? inst.r.rd : inst.r.rt;

  assign ctrl.is_br  = (op1[5:2] == 4'b0010);
  assign ctrl.is_jmp = (op1 == cpu_pkg::op1_jal);
  assign ctrl.rd_mem = (op1 == cpu_pkg::op1_lw);
  assign ctrl.wr_mem = (op1 == cpu_pkg::op1_sw);
  assign ctrl.wr_reg = writes_class && (dest != '0); // r0 target counts as no write

  assign wregno  = ctrl.wr_reg ? dest : '0;
  assign sxt_imm = {{(cpu_pkg::dbits - cpu_pkg::imm_bits){inst.i.imm[cpu_pkg::imm_bits-1]}},
                    inst.i.imm};

  // Hazard check --------------------
  assign uses_rt = is_alur || ctrl.is_br || ctrl.wr_mem; // SW stores rt
  assign stall   = pending(inst.r.rs, id_ex.wregno, ex_wregno, mem_wregno) ||
                   (uses_rt && pending(inst.r.rt, id_ex.wregno, ex_wregno, mem_wregno));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      id_ex <= '0;
    end else if (redirect.valid || stall) begin
      id_ex <= '0; // Flush or bubble
    end else begin
      id_ex.op1     <= op1;
      id_ex.op2     <= inst.r.op2;
      id_ex.regval1 <= regval1;
      id_ex.regval2 <= regval2;
      id_ex.imm     <= sxt_imm;
      id_ex.wregno  <= wregno;
      id_ex.ctrl    <= ctrl;
      id_ex.pc_plus <= fe_id.pc_plus;
    end
  end

  // Three older instructions drain within three stall cycles
  a_stall_len: assert property (@(posedge clk) disable iff (reset)
    (stall && $past(stall) && $past(stall, 2)) |=> !stall);

endmodule

// File: fetch_stage.sv
module fetch_stage #(
  parameter logic [cpu_pkg::dbits-1:0] start_pc = 32'h100,
  parameter int imem_addr_bits = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         stall,
  input  cpu_pkg::redirect_t           redirect,
  input  logic                         imem_we,
  input  logic [imem_addr_bits-1:0]    imem_addr, // Word index
  input  logic [cpu_pkg::dbits-1:0]    imem_data,
  output cpu_pkg::fe_id_t              fe_id
);

  localparam int imem_words = 1 << (imem_addr_bits - 2);

  logic [cpu_pkg::dbits-1:0] imem [imem_words];
  logic [cpu_pkg::dbits-1:0] pc;
  logic [cpu_pkg::dbits-1:0] pc_plus;

  assign pc_plus = pc + 32'd4;

  // Load port, usable while the core sits in reset
  always_ff @(posedge clk) begin
    if (imem_we)
      imem[imem_addr[imem_addr_bits-3:0]] <= imem_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc    <= start_pc;
      fe_id <= '0;
    end else if (redirect.valid) begin
      pc    <= redirect.target;
      fe_id <= '0; // Bubble
    end else if (!stall) begin
      pc            <= pc_plus;
      fe_id.inst    <= imem[pc[imem_addr_bits-1:2]];
      fe_id.pc_plus <= pc_plus;
    end
  end

  a_load_in_reset: assert property (@(posedge clk) imem_we |-> reset);

endmodule

// File: reg_file.sv
module reg_file (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [cpu_pkg::regno_bits-1:0]   rs,
  input  logic [cpu_pkg::regno_bits-1:0]   rt,
  input  cpu_pkg::mem_wb_t                 wb,
  output logic [cpu_pkg::dbits-1:0]        rval1,
  output logic [cpu_pkg::dbits-1:0]        rval2
);

  localparam int num_regs = 1 << cpu_pkg::regno_bits;

  logic [cpu_pkg::dbits-1:0] regs [1:num_regs-1]; // No storage for r0

  // Falling edge write, so decode sees the value in the same cycle
  always_ff @(negedge clk or posedge reset) begin
    if (reset) begin
      for (int n = 1; n < num_regs; n++)
        regs[n] <= '0;
    end else if (wb.wr_reg && wb.wregno != '0) begin
      regs[wb.wregno] <= wb.wval;
    end
  end

  assign rval1 = (rs == '0) ? '0 : regs[rs];
  assign rval2 = (rt == '0) ? '0 : regs[rt];

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

  // Widths --------------------
  localparam int dbits      = 32;
  localparam int regno_bits = 4;
  localparam int imm_bits   = 16;
  localparam int hex_bits   = 24;
  localparam int ledr_bits  = 10;
  localparam int key_bits   = 4;

  // Opcodes --------------------
  typedef logic [5:0] op1_t;
  typedef logic [7:0] op2_t;

  localparam op1_t op1_alur = 6'b000000;
  localparam op1_t op1_beq  = 6'b001000; // Branches share 0010xx
  localparam op1_t op1_blt  = 6'b001001;
  localparam op1_t op1_ble  = 6'b001010;
  localparam op1_t op1_bne  = 6'b001011;
  localparam op1_t op1_jal  = 6'b001100;
  localparam op1_t op1_lw   = 6'b010010;
  localparam op1_t op1_sw   = 6'b011010;
  localparam op1_t op1_addi = 6'b100000; // ALU immediates share 100xxx
  localparam op1_t op1_andi = 6'b100100;
  localparam op1_t op1_ori  = 6'b100101;
  localparam op1_t op1_xori = 6'b100110;

  localparam op2_t op2_eq   = 8'b00001000;
  localparam op2_t op2_lt   = 8'b00001001;
  localparam op2_t op2_le   = 8'b00001010;
  localparam op2_t op2_ne   = 8'b00001011;
  localparam op2_t op2_add  = 8'b00100000;
  localparam op2_t op2_and  = 8'b00100100;
  localparam op2_t op2_or   = 8'b00100101;
  localparam op2_t op2_xor  = 8'b00100110;
  localparam op2_t op2_sub  = 8'b00101000;
  localparam op2_t op2_nand = 8'b00101100;
  localparam op2_t op2_nor  = 8'b00101101;
  localparam op2_t op2_nxor = 8'b00101110;
  localparam op2_t op2_rshf = 8'b00110000;
  localparam op2_t op2_lshf = 8'b00110001;

  // Memory-mapped I/O
  localparam logic [dbits-1:0] addr_hex  = 32'hFFFFF000;
  localparam logic [dbits-1:0] addr_ledr = 32'hFFFFF020;
  localparam logic [dbits-1:0] addr_key  = 32'hFFFFF080;

  // Instruction word, R-type and immediate views of the same bits
  typedef union packed {
    struct packed {
      op1_t                  op1;
      op2_t                  op2;
      logic [5:0]            spare;
      logic [regno_bits-1:0] rd;
      logic [regno_bits-1:0] rs;
      logic [regno_bits-1:0] rt;
    } r;
    struct packed {
      op1_t                  op1;
      logic [1:0]            spare;
      logic [imm_bits-1:0]   imm;
      logic [regno_bits-1:0] rs;
      logic [regno_bits-1:0] rt;
    } i;
  } inst_u;

  // Stage latches --------------------
  typedef struct packed {
    inst_u            inst;
    logic [dbits-1:0] pc_plus; // Fetch address + 4
  } fe_id_t;

  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  typedef struct packed {
    op1_t                  op1;
    op2_t                  op2;
    logic [dbits-1:0]      regval1;
    logic [dbits-1:0]      regval2;
    logic [dbits-1:0]      imm;     // Sign extended
    logic [regno_bits-1:0] wregno;
    ctrl_t                 ctrl;
    logic [dbits-1:0]      pc_plus;
  } id_ex_t;

  typedef struct packed {
    logic [dbits-1:0]      aluout;
    logic [dbits-1:0]      sdata;   // Store data from rt
    logic [regno_bits-1:0] wregno;
    logic                  rd_mem;
    logic                  wr_mem;
    logic                  wr_reg;
  } ex_mem_t;

  typedef struct packed {
    logic [dbits-1:0]      wval;
    logic [regno_bits-1:0] wregno;
    logic                  wr_reg;
  } mem_wb_t;

  typedef struct packed {
    logic             valid;
    logic [dbits-1:0] target;
  } redirect_t;

endpackage
